// ==== verilog/pcie_dma_config.svh ====
// pcie dma configuration
// stream width, user buffer depth, transfer limit and apb register map

`ifndef PCIE_DMA_CONFIG_SVH
`define PCIE_DMA_CONFIG_SVH

// tlp stream beat width
`define PCIE_DMA_DATA_W       128
// user buffer address width, in beats
`define PCIE_DMA_ADDR_W       12
// longest dma write, in beats
`define PCIE_DMA_MAX_BEATS    16

// apb register map
`define PCIE_DMA_APB_ADDR_W   9
`define PCIE_DMA_REG_ADDR     9'h000
`define PCIE_DMA_REG_LEN      9'h004
`define PCIE_DMA_REG_CTRL     9'h008

`endif

// ==== verilog/pcie_dma_pkg.sv ====
// pcie dma package
// shared vector types, tlp header layout and stage-to-stage structs

`include "pcie_dma_config.svh"

`default_nettype none

package pcie_dma_pkg;

    typedef logic [`PCIE_DMA_DATA_W-1:0] beat_t;
    typedef logic [`PCIE_DMA_ADDR_W-1:0] buf_addr_t;
    typedef logic [31:0]                 host_addr_t;
    typedef logic [4:0]                  len_t;
    typedef logic [9:0]                  dw_len_t;
    typedef logic [15:0]                 req_id_t;

    typedef enum logic [7:0] {
        MRD32 = 8'h00,
        MWR32 = 8'h40,
        MWR64 = 8'h60
    } tlp_fmt_type_e;

    // 3dw header, dw0 in the top bits
    typedef struct packed {
        tlp_fmt_type_e fmt_type;
        logic [13:0]   tc_attr;
        dw_len_t       length_dw;
        req_id_t       req_id;
        logic [7:0]    tag;
        logic [3:0]    last_be;
        logic [3:0]    first_be;
        logic [29:0]   addr_dw;
        logic [1:0]    rsvd;
    } mwr_hdr_t;

    typedef struct packed {
        host_addr_t addr;
        len_t       len;
    } dma_req_t;

    typedef struct packed {
        beat_t data;
        logic  last;
    } stream_beat_t;

    typedef struct packed {
        logic      en;
        buf_addr_t addr;
        beat_t     data;
    } buf_wr_t;

endpackage

`default_nettype wire

// ==== verilog/pcie_dma_apb_regs.sv ====
// dma register block on apb
// holds host address and beat length, launches a write and tracks busy

`include "pcie_dma_config.svh"

`default_nettype none

module pcie_dma_apb_regs (
    input  wire                               clk,
    input  wire                               i_rst_n,
    input  wire                               i_apb_psel,
    input  wire                               i_apb_penable,
    input  wire                               i_apb_pwrite,
    input  wire [`PCIE_DMA_APB_ADDR_W-1:0]    i_apb_paddr,
    input  wire [31:0]                        i_apb_pwdata,
    output logic                              o_apb_prdy,
    output logic [31:0]                       o_apb_prdata,
    input  wire                               i_done,
    output logic                              o_start,
    output pcie_dma_pkg::dma_req_t            o_req
);

    import pcie_dma_pkg::*;

    host_addr_t  addr_q;
    len_t        len_q;
    logic        busy;
    logic        wr_en;
    logic        start_wr;
    logic [31:0] rd_mux;

    // zero wait state, ready in the access phase
    assign o_apb_prdy = i_apb_psel & i_apb_penable;
    assign wr_en      = o_apb_prdy & i_apb_pwrite;

    // start only when idle
    assign start_wr = wr_en && (i_apb_paddr == `PCIE_DMA_REG_CTRL)
                      && i_apb_pwdata[0] && !busy;

    assign o_req = '{addr: addr_q, len: len_q};

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            addr_q  <= '0;
            len_q   <= len_t'(1);
            busy    <= 1'b0;
            o_start <= 1'b0;
        end
        else
        begin
            o_start <= start_wr;
            if (start_wr)
                busy <= 1'b1;
            else if (i_done)
                busy <= 1'b0;

            if (wr_en && (i_apb_paddr == `PCIE_DMA_REG_ADDR))
                addr_q <= i_apb_pwdata;

            // length kept within 1..max beats
            if (wr_en && (i_apb_paddr == `PCIE_DMA_REG_LEN))
            begin
                if (i_apb_pwdata > `PCIE_DMA_MAX_BEATS)
                    len_q <= len_t'(`PCIE_DMA_MAX_BEATS);
                else if (i_apb_pwdata == '0)
                    len_q <= len_t'(1);
                else
                    len_q <= len_t'(i_apb_pwdata);
            end
        end
    end

    always_comb
    begin
        case (i_apb_paddr)
            `PCIE_DMA_REG_ADDR: rd_mux = addr_q;
            `PCIE_DMA_REG_LEN:  rd_mux = 32'(len_q);
            `PCIE_DMA_REG_CTRL: rd_mux = {31'd0, busy};
            default:            rd_mux = '0;
        endcase
    end

    // read data captured in the setup phase
    always_ff @(posedge clk)
    begin
        if (i_apb_psel && !i_apb_penable)
            o_apb_prdata <= rd_mux;
    end

endmodule

`default_nettype wire

// ==== verilog/pcie_dma_mwr_tx.sv ====
// memory write tlp transmitter
// sends a 3dw mwr32 header then the payload fetched from the user port,
// with a two-entry prefetch buffer to ride out slave back-pressure

`default_nettype none

module pcie_dma_mwr_tx (
    input  wire                               clk,
    input  wire                               i_rst_n,
    input  wire                               i_start,
    input  wire pcie_dma_pkg::dma_req_t       i_req,
    input  wire pcie_dma_pkg::req_id_t        i_req_id,
    output logic                              o_done,
    output logic                              o_dma_write_data_req,
    output pcie_dma_pkg::buf_addr_t           o_dma_write_addr,
    input  wire pcie_dma_pkg::beat_t          i_dma_write_data,
    output logic                              o_axis_slave_tvld,
    output pcie_dma_pkg::stream_beat_t        o_axis_slave_beat,
    input  wire                               i_axis_slave_trdy
);

    import pcie_dma_pkg::*;

    typedef enum logic [1:0] {IDLE, HDR, DATA} tx_state_e;

    tx_state_e    state;
    dma_req_t     req_q;
    mwr_hdr_t     hdr;
    len_t         req_cnt;
    logic         rd_pend;
    logic         rd_pend_last;
    stream_beat_t fifo_mem [2];
    logic         wr_ptr;
    logic         rd_ptr;
    logic [1:0]   fifo_cnt;
    logic [1:0]   occ;
    logic         pop;
    logic         fetch;

    assign hdr = '{fmt_type:  MWR32,
                   tc_attr:   '0,
                   length_dw: {3'b000, req_q.len, 2'b00},
                   req_id:    i_req_id,
                   tag:       '0,
                   last_be:   4'hf,
                   first_be:  4'hf,
                   addr_dw:   req_q.addr[31:2],
                   rsvd:      2'b00};

    assign pop = (state == DATA) && (fifo_cnt != 2'd0) && i_axis_slave_trdy;

    // entries held plus the read still in flight
    assign occ   = fifo_cnt + {1'b0, rd_pend};
    assign fetch = (state != IDLE) && (req_cnt != req_q.len) && ((occ < 2'd2) || pop);

    assign o_dma_write_data_req = fetch;
    assign o_dma_write_addr     = buf_addr_t'(req_cnt);

    assign o_axis_slave_tvld = (state == HDR) || ((state == DATA) && (fifo_cnt != 2'd0));

    always_comb
    begin
        if (state == HDR)
        begin
            o_axis_slave_beat.data = beat_t'(hdr);
            o_axis_slave_beat.last = 1'b0;
        end
        else
        begin
            o_axis_slave_beat = fifo_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state        <= IDLE;
            req_cnt      <= '0;
            rd_pend      <= 1'b0;
            rd_pend_last <= 1'b0;
            fifo_cnt     <= 2'd0;
            wr_ptr       <= 1'b0;
            rd_ptr       <= 1'b0;
            o_done       <= 1'b0;
        end
        else
        begin
            o_done       <= 1'b0;
            rd_pend      <= fetch;
            rd_pend_last <= fetch && (req_cnt == req_q.len - len_t'(1));
            fifo_cnt     <= fifo_cnt + {1'b0, rd_pend} - {1'b0, pop};
            if (fetch)
                req_cnt <= req_cnt + len_t'(1);
            if (rd_pend)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;

            case (state)
                IDLE:
                begin
                    if (i_start)
                    begin
                        state   <= HDR;
                        req_cnt <= '0;
                    end
                end
                HDR:
                begin
                    if (i_axis_slave_trdy)
                        state <= DATA;
                end
                DATA:
                begin
                    // tlast handshake closes the tlp
                    if (pop && fifo_mem[rd_ptr].last)
                    begin
                        state  <= IDLE;
                        o_done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_start && (state == IDLE))
            req_q <= i_req;
        if (rd_pend)
            fifo_mem[wr_ptr] <= '{data: i_dma_write_data, last: rd_pend_last};
    end

endmodule

`default_nettype wire

// ==== verilog/pcie_dma_mwr_rx.sv ====
// memory write tlp receiver
// decodes the header beat, writes mwr32 payload into the rx buffer,
// drops every other tlp type

`include "pcie_dma_config.svh"

`default_nettype none

module pcie_dma_mwr_rx (
    input  wire                               clk,
    input  wire                               i_rst_n,
    input  wire                               i_axis_master_tvld,
    input  wire pcie_dma_pkg::beat_t          i_axis_master_tdata,
    input  wire                               i_axis_master_tlast,
    output pcie_dma_pkg::buf_wr_t             o_buf_wr
);

    import pcie_dma_pkg::*;

    mwr_hdr_t  rx_hdr;
    logic      in_pkt;
    logic      wr_act;
    buf_addr_t wr_addr;
    logic      wr_en_q;
    buf_addr_t wr_addr_q;
    beat_t     wr_data_q;

    assign rx_hdr = mwr_hdr_t'(i_axis_master_tdata[$bits(mwr_hdr_t)-1:0]);

    // ************************************************************
    // header decode and beat address
    // ************************************************************
    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            in_pkt  <= 1'b0;
            wr_act  <= 1'b0;
            wr_addr <= '0;
            wr_en_q <= 1'b0;
        end
        else
        begin
            wr_en_q <= 1'b0;
            if (i_axis_master_tvld)
            begin
                // header-only tlps end on their first beat
                in_pkt <= !i_axis_master_tlast;
                if (!in_pkt)
                begin
                    wr_act <= (rx_hdr.fmt_type == MWR32);
                    // byte address bits 15:4 give the start beat
                    wr_addr <= rx_hdr.addr_dw[`PCIE_DMA_ADDR_W+1:2];
                end
                else if (wr_act)
                begin
                    wr_en_q <= 1'b1;
                    wr_addr <= wr_addr + buf_addr_t'(1);
                end
            end
        end
    end

    // ************************************************************
    // buffer write, one cycle behind the beat
    // ************************************************************
    always_ff @(posedge clk)
    begin
        if (i_axis_master_tvld && in_pkt)
        begin
            wr_addr_q <= wr_addr;
            wr_data_q <= i_axis_master_tdata;
        end
    end

    assign o_buf_wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

endmodule

`default_nettype wire

// ==== verilog/pcie_dma_rx_ram.sv ====
// receive buffer
// one beat-wide write port from the rx parser, registered user read port

`include "pcie_dma_config.svh"

`default_nettype none

module pcie_dma_rx_ram (
    input  wire                               clk,
    input  wire pcie_dma_pkg::buf_wr_t        i_buf_wr,
    input  wire                               i_rd_req,
    input  wire pcie_dma_pkg::buf_addr_t      i_rd_addr,
    output pcie_dma_pkg::beat_t               o_rd_data
);

    import pcie_dma_pkg::*;

    beat_t mem [0:(1 << `PCIE_DMA_ADDR_W)-1];

    always_ff @(posedge clk)
    begin
        if (i_buf_wr.en)
            mem[i_buf_wr.addr] <= i_buf_wr.data;
        // read data holds until the next request
        if (i_rd_req)
            o_rd_data <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/pcie_dma_top.sv ====
// pcie dma engine top
// apb register stage and mwr transmit on the slave stream,
// mwr receive into the on-chip buffer from the master stream

`include "pcie_dma_config.svh"

`default_nettype none

module pcie_dma_top (
    input  wire                               clk,
    input  wire                               i_rst_n,
    input  wire [7:0]                         i_cfg_pbus_num,
    input  wire [4:0]                         i_cfg_pbus_dev_num,
    // apb
    input  wire                               i_apb_psel,
    input  wire                               i_apb_penable,
    input  wire                               i_apb_pwrite,
    input  wire [`PCIE_DMA_APB_ADDR_W-1:0]    i_apb_paddr,
    input  wire [31:0]                        i_apb_pwdata,
    output logic                              o_apb_prdy,
    output logic [31:0]                       o_apb_prdata,
    // axis master, host to fpga
    input  wire                               i_axis_master_tvld,
    input  wire pcie_dma_pkg::beat_t          i_axis_master_tdata,
    input  wire                               i_axis_master_tlast,
    // axis slave, fpga to host
    output logic                              o_axis_slave_tvld,
    output pcie_dma_pkg::beat_t               o_axis_slave_tdata,
    output logic                              o_axis_slave_tlast,
    input  wire                               i_axis_slave_trdy,
    // user side
    output logic                              o_dma_write_data_req,
    output pcie_dma_pkg::buf_addr_t           o_dma_write_addr,
    input  wire pcie_dma_pkg::beat_t          i_dma_write_data,
    input  wire                               i_dma_read_data_req,
    input  wire pcie_dma_pkg::buf_addr_t      i_dma_read_addr,
    output pcie_dma_pkg::beat_t               o_dma_read_data
);

    import pcie_dma_pkg::*;

    dma_req_t     dma_req;
    logic         dma_start;
    logic         dma_done;
    req_id_t      req_id;
    stream_beat_t tx_beat;
    buf_wr_t      buf_wr;

    // function number is always zero
    assign req_id = {i_cfg_pbus_num, i_cfg_pbus_dev_num, 3'b000};

    assign o_axis_slave_tdata = tx_beat.data;
    assign o_axis_slave_tlast = tx_beat.last;

    // ************************************************************
    // transmit chain
    // ************************************************************
    pcie_dma_apb_regs u_pcie_dma_apb_regs (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_apb_psel     (i_apb_psel),
        .i_apb_penable  (i_apb_penable),
        .i_apb_pwrite   (i_apb_pwrite),
        .i_apb_paddr    (i_apb_paddr),
        .i_apb_pwdata   (i_apb_pwdata),
        .o_apb_prdy     (o_apb_prdy),
        .o_apb_prdata   (o_apb_prdata),
        .i_done         (dma_done),
        .o_start        (dma_start),
        .o_req          (dma_req)
    );

    pcie_dma_mwr_tx u_pcie_dma_mwr_tx (
        .clk                  (clk),
        .i_rst_n              (i_rst_n),
        .i_start              (dma_start),
        .i_req                (dma_req),
        .i_req_id             (req_id),
        .o_done               (dma_done),
        .o_dma_write_data_req (o_dma_write_data_req),
        .o_dma_write_addr     (o_dma_write_addr),
        .i_dma_write_data     (i_dma_write_data),
        .o_axis_slave_tvld    (o_axis_slave_tvld),
        .o_axis_slave_beat    (tx_beat),
        .i_axis_slave_trdy    (i_axis_slave_trdy)
    );

    // ************************************************************
    // receive chain
    // ************************************************************
    pcie_dma_mwr_rx u_pcie_dma_mwr_rx (
        .clk                 (clk),
        .i_rst_n             (i_rst_n),
        .i_axis_master_tvld  (i_axis_master_tvld),
        .i_axis_master_tdata (i_axis_master_tdata),
        .i_axis_master_tlast (i_axis_master_tlast),
        .o_buf_wr            (buf_wr)
    );

    pcie_dma_rx_ram u_pcie_dma_rx_ram (
        .clk        (clk),
        .i_buf_wr   (buf_wr),
        .i_rd_req   (i_dma_read_data_req),
        .i_rd_addr  (i_dma_read_addr),
        .o_rd_data  (o_dma_read_data)
    );

endmodule

`default_nettype wire

// ==== test/tb_pcie_dma_tasks.svh ====
// testbench helpers for the pcie dma engine
// lfsr, compare tasks, apb and stream drivers, directed tests

`ifndef TB_PCIE_DMA_TASKS_SVH
`define TB_PCIE_DMA_TASKS_SVH

// 32-bit fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic take_bit();
    lfsr_q = lfsr_next(lfsr_q);
    return lfsr_q[0];
endfunction

function automatic beat_t random_beat();
    beat_t b;
    for (int i = 0; i < `PCIE_DMA_DATA_W; i++)
        b[i] = take_bit();
    return b;
endfunction

task automatic stop_on_error(input string msg);
    failed = 1'b1;
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopped at the first error");
endtask

// ************************************************************
// compare tasks
// ************************************************************
task automatic compare_beat(input string name, input beat_t got, input beat_t exp);
    if (got !== exp)
        stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
                                $time, name, got, exp));
endtask

task automatic compare_hdr(input string name, input mwr_hdr_t got, input mwr_hdr_t exp);
    if (got !== exp)
        stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
                                $time, name, got, exp));
endtask

task automatic compare_reg(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp)
        stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
                                $time, name, got, exp));
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
        stop_on_error($sformatf("mismatch at %0t: %s got %b expected %b",
                                $time, name, got, exp));
endtask

// ************************************************************
// bus drivers and waits
// ************************************************************
task automatic apb_access(input logic write, input logic [`PCIE_DMA_APB_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    @(negedge clk);
    apb_psel    = 1'b1;
    apb_penable = 1'b0;
    apb_pwrite  = write;
    apb_paddr   = addr;
    apb_pwdata  = wdata;
    @(negedge clk);
    apb_penable = 1'b1;
    cycles = 0;
    do
    begin
        @(posedge clk);
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
            stop_on_error("apb transfer never got ready");
    end
    while (!o_apb_prdy);
    rdata = o_apb_prdata;
    @(negedge clk);
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
    apb_pwrite  = 1'b0;
endtask

task automatic apb_write(input logic [`PCIE_DMA_APB_ADDR_W-1:0] addr,
                         input logic [31:0] data);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused);
endtask

task automatic apb_read(input logic [`PCIE_DMA_APB_ADDR_W-1:0] addr,
                        output logic [31:0] data);
    apb_access(1'b0, addr, '0, data);
endtask

task automatic wait_tx_beats(input int count);
    int cycles;
    cycles = 0;
    while (tx_beats.size() < count)
    begin
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
            stop_on_error($sformatf("timeout waiting for %0d slave stream beats", count));
    end
endtask

task automatic send_beat(input beat_t data, input logic last);
    @(negedge clk);
    m_tvld  = 1'b1;
    m_tdata = data;
    m_tlast = last;
endtask

task automatic send_idle();
    @(negedge clk);
    m_tvld  = 1'b0;
    m_tlast = 1'b0;
endtask

// registered read with data valid one cycle after the request
task automatic read_buf(input buf_addr_t addr, output beat_t data);
    @(negedge clk);
    rd_req  = 1'b1;
    rd_addr = addr;
    @(negedge clk);
    rd_req = 1'b0;
    data   = o_dma_read_data;
endtask

task automatic fill_user_table();
    for (int i = 0; i < `PCIE_DMA_MAX_BEATS; i++)
        user_table[i] = random_beat();
endtask

// ************************************************************
// directed tests
// ************************************************************
task automatic test_reset_and_regs();
    logic [31:0] rd;
    @(negedge clk);
    compare_bit("o_axis_slave_tvld", o_axis_slave_tvld, 1'b0);
    compare_bit("o_dma_write_data_req", o_dma_write_data_req, 1'b0);
    compare_bit("o_apb_prdy", o_apb_prdy, 1'b0);
    apb_write(`PCIE_DMA_REG_ADDR, 32'hdead_beec);
    apb_read(`PCIE_DMA_REG_ADDR, rd);
    compare_reg("address register", rd, 32'hdead_beec);
    apb_write(`PCIE_DMA_REG_LEN, 32'd9);
    apb_read(`PCIE_DMA_REG_LEN, rd);
    compare_reg("length register", rd, 32'd9);
    apb_read(`PCIE_DMA_REG_CTRL, rd);
    compare_reg("control register", rd, 32'd0);
endtask

task automatic test_dma_write(input host_addr_t addr, input len_t len,
                              input logic rand_trdy);
    mwr_hdr_t     exp_hdr;
    stream_beat_t b;
    logic [31:0]  rd;
    exp_hdr = '{fmt_type:  MWR32,
                tc_attr:   '0,
                length_dw: dw_len_t'(4 * int'(len)),
                req_id:    {cfg_bus, cfg_dev, 3'b000},
                tag:       '0,
                last_be:   4'hf,
                first_be:  4'hf,
                addr_dw:   addr[31:2],
                rsvd:      2'b00};
    // lfsr is only stepped here while the trdy process is quiet
    @(posedge clk);
    fill_user_table();
    tx_beats.delete();
    rand_trdy_en = rand_trdy;

    apb_write(`PCIE_DMA_REG_ADDR, addr);
    apb_write(`PCIE_DMA_REG_LEN, 32'(len));
    apb_write(`PCIE_DMA_REG_CTRL, 32'd1);
    apb_read(`PCIE_DMA_REG_CTRL, rd);
    compare_reg("busy during transfer", rd, 32'd1);

    wait_tx_beats(int'(len) + 1);
    // busy drops the cycle after done
    @(posedge clk);
    apb_read(`PCIE_DMA_REG_CTRL, rd);
    compare_reg("busy after tlast", rd, 32'd0);
    @(posedge clk);
    rand_trdy_en = 1'b0;
    compare_reg("slave beat count", 32'(tx_beats.size()), 32'(len) + 32'd1);

    b = tx_beats[0];
    compare_hdr("header beat", mwr_hdr_t'(b.data[95:0]), exp_hdr);
    compare_reg("header upper dword", b.data[127:96], 32'd0);
    compare_bit("header tlast", b.last, 1'b0);
    for (int k = 1; k <= int'(len); k++)
    begin
        b = tx_beats[k];
        compare_beat($sformatf("data beat %0d", k), b.data, user_table[k-1]);
        compare_bit($sformatf("tlast of beat %0d", k), b.last, k == int'(len));
    end
endtask

task automatic test_rx_mwr(input host_addr_t addr, input int beats);
    mwr_hdr_t  hdr;
    beat_t     got;
    buf_addr_t base;
    hdr = '{fmt_type:  MWR32,
            tc_attr:   '0,
            length_dw: dw_len_t'(4 * beats),
            req_id:    16'h0100,
            tag:       8'h05,
            last_be:   4'hf,
            first_be:  4'hf,
            addr_dw:   addr[31:2],
            rsvd:      2'b00};
    base = addr[15:4];
    rx_expect.delete();
    for (int i = 0; i < beats; i++)
        rx_expect.push_back(random_beat());

    // one idle gap after the header
    send_beat(beat_t'(hdr), 1'b0);
    send_idle();
    for (int i = 0; i < beats; i++)
        send_beat(rx_expect[i], i == beats - 1);
    send_idle();

    for (int i = 0; i < beats; i++)
    begin
        read_buf(base + buf_addr_t'(i), got);
        compare_beat($sformatf("o_dma_read_data at beat %0d", i), got, rx_expect[i]);
    end
endtask

task automatic test_rx_mrd(input host_addr_t addr, input int beats);
    mwr_hdr_t  hdr;
    beat_t     got;
    buf_addr_t base;
    hdr = '{fmt_type:  MRD32,
            tc_attr:   '0,
            length_dw: dw_len_t'(4 * beats),
            req_id:    16'h0100,
            tag:       8'h06,
            last_be:   4'hf,
            first_be:  4'hf,
            addr_dw:   addr[31:2],
            rsvd:      2'b00};
    base = addr[15:4];
    // beats behind a non-mwr header are consumed without a buffer write
    send_beat(beat_t'(hdr), 1'b0);
    for (int i = 0; i < beats; i++)
        send_beat(random_beat(), i == beats - 1);
    send_idle();
    for (int i = 0; i < beats; i++)
    begin
        read_buf(base + buf_addr_t'(i), got);
        compare_beat($sformatf("o_dma_read_data after mrd at beat %0d", i), got,
                     rx_expect[i]);
    end
endtask

`endif

// ==== test/tb_pcie_dma.sv ====
// testbench for the pcie dma engine
// host stream sink with random back-pressure, user write-data model,
// directed apb, transmit and receive tests

`include "pcie_dma_config.svh"

`default_nettype none

module tb_pcie_dma;

    import pcie_dma_pkg::*;

    localparam int TIMEOUT_CYCLES = 1000;

    logic                            clk;
    logic                            rst_n;
    logic [7:0]                      cfg_bus;
    logic [4:0]                      cfg_dev;
    logic                            apb_psel;
    logic                            apb_penable;
    logic                            apb_pwrite;
    logic [`PCIE_DMA_APB_ADDR_W-1:0] apb_paddr;
    logic [31:0]                     apb_pwdata;
    logic                            o_apb_prdy;
    logic [31:0]                     o_apb_prdata;
    logic                            m_tvld;
    beat_t                           m_tdata;
    logic                            m_tlast;
    logic                            o_axis_slave_tvld;
    beat_t                           o_axis_slave_tdata;
    logic                            o_axis_slave_tlast;
    logic                            host_trdy;
    logic                            o_dma_write_data_req;
    buf_addr_t                       o_dma_write_addr;
    beat_t                           user_wdata;
    logic                            rd_req;
    buf_addr_t                       rd_addr;
    beat_t                           o_dma_read_data;

    // user table, lfsr and scoreboard state
    beat_t        user_table [0:`PCIE_DMA_MAX_BEATS-1];
    beat_t        rx_expect [$];
    stream_beat_t tx_beats [$];
    logic [31:0]  lfsr_q;
    logic         rand_trdy_en;
    logic         failed;
    logic         wr_req_q;
    buf_addr_t    wr_addr_q;
    logic         hold_pending;
    stream_beat_t held_beat;

    `include "tb_pcie_dma_tasks.svh"

    pcie_dma_top dut_i (
        .clk                  (clk),
        .i_rst_n              (rst_n),
        .i_cfg_pbus_num       (cfg_bus),
        .i_cfg_pbus_dev_num   (cfg_dev),
        .i_apb_psel           (apb_psel),
        .i_apb_penable        (apb_penable),
        .i_apb_pwrite         (apb_pwrite),
        .i_apb_paddr          (apb_paddr),
        .i_apb_pwdata         (apb_pwdata),
        .o_apb_prdy           (o_apb_prdy),
        .o_apb_prdata         (o_apb_prdata),
        .i_axis_master_tvld   (m_tvld),
        .i_axis_master_tdata  (m_tdata),
        .i_axis_master_tlast  (m_tlast),
        .o_axis_slave_tvld    (o_axis_slave_tvld),
        .o_axis_slave_tdata   (o_axis_slave_tdata),
        .o_axis_slave_tlast   (o_axis_slave_tlast),
        .i_axis_slave_trdy    (host_trdy),
        .o_dma_write_data_req (o_dma_write_data_req),
        .o_dma_write_addr     (o_dma_write_addr),
        .i_dma_write_data     (user_wdata),
        .i_dma_read_data_req  (rd_req),
        .i_dma_read_addr      (rd_addr),
        .o_dma_read_data      (o_dma_read_data)
    );

    always #20 clk = ~clk;

    // ************************************************************
    // host sink and user write-data model
    // ************************************************************
    always @(negedge clk)
    begin
        if (rand_trdy_en)
            host_trdy <= take_bit();
        else
            host_trdy <= 1'b1;
    end

    always @(posedge clk)
    begin
        wr_req_q  <= o_dma_write_data_req;
        wr_addr_q <= o_dma_write_addr;
    end

    // data answers one cycle after the request
    always @(negedge clk)
    begin
        if (wr_req_q)
        begin
            if (wr_addr_q >= `PCIE_DMA_MAX_BEATS)
                stop_on_error("write-data request outside the user table");
            else
                user_wdata <= user_table[wr_addr_q];
        end
    end

    // slave stream monitor, beats must hold while stalled
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (hold_pending)
            begin
                compare_bit("o_axis_slave_tvld", o_axis_slave_tvld, 1'b1);
                compare_beat("o_axis_slave_tdata", o_axis_slave_tdata, held_beat.data);
                compare_bit("o_axis_slave_tlast", o_axis_slave_tlast, held_beat.last);
            end
            if (o_axis_slave_tvld && host_trdy)
                tx_beats.push_back('{data: o_axis_slave_tdata, last: o_axis_slave_tlast});
            hold_pending = o_axis_slave_tvld && !host_trdy;
            held_beat    = '{data: o_axis_slave_tdata, last: o_axis_slave_tlast};
        end
    end

    // ************************************************************
    // test sequence
    // ************************************************************
    initial
    begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        cfg_bus      = 8'h3a;
        cfg_dev      = 5'h11;
        apb_psel     = 1'b0;
        apb_penable  = 1'b0;
        apb_pwrite   = 1'b0;
        apb_paddr    = '0;
        apb_pwdata   = '0;
        m_tvld       = 1'b0;
        m_tdata      = '0;
        m_tlast      = 1'b0;
        host_trdy    = 1'b0;
        user_wdata   = '0;
        rd_req       = 1'b0;
        rd_addr      = '0;
        lfsr_q       = 32'he45;
        rand_trdy_en = 1'b0;
        failed       = 1'b0;
        hold_pending = 1'b0;
        held_beat    = '0;

        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        test_reset_and_regs();
        test_dma_write(32'h8000_1003, len_t'(4), 1'b0);
        test_dma_write(32'h0123_4560, len_t'(16), 1'b1);
        test_dma_write(32'hfffe_0008, len_t'(1), 1'b1);
        test_rx_mwr(32'h0001_2340, 5);
        test_rx_mrd(32'h0001_2340, 5);

        repeat (2) @(negedge clk);
        if (!failed)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verilog
+incdir+test
verilog/pcie_dma_pkg.sv
verilog/pcie_dma_apb_regs.sv
verilog/pcie_dma_mwr_tx.sv
verilog/pcie_dma_mwr_rx.sv
verilog/pcie_dma_rx_ram.sv
verilog/pcie_dma_top.sv
test/tb_pcie_dma.sv
